// ==== files.f ====
src/roc_pkg.sv
src/roc_region_decode.sv
src/roc_line_store.sv
src/roc_refill.sv
src/roc_top.sv
tb/tb_clock_gen.sv
tb/tb_roc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the read-only cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_roc_top \
  -o sim_roc \
  && ./obj_dir/sim_roc | tee "$LOG" \
  && grep -q "TEST PASSED" "$LOG" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src/roc_line_store.sv ====
// Direct-mapped line store with registered lookup, line fill and flush
`timescale 1ns/1ps
`default_nettype none

module roc_line_store #(
  parameter int unsigned LineCount = 16
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  // From the decode stage
  input  wire roc_pkg::req_t    in_req_i,
  input  wire logic             in_cacheable_i,
  input  wire logic             in_valid_i,
  output logic                  in_ready_o,
  // Towards the refill stage
  output roc_pkg::lookup_t      out_o,
  output logic                  out_valid_o,
  input  wire logic             out_ready_i,
  // Line write
  input  wire roc_pkg::fill_t   fill_i,
  input  wire logic             fill_valid_i,
  // Invalidate all lines
  input  wire logic             flush_i
);

  localparam int unsigned OffsetWidth = $clog2(roc_pkg::DataWidth / 8);
  localparam int unsigned IdxWidth    = $clog2(LineCount);
  localparam int unsigned TagWidth    = roc_pkg::AddrWidth - IdxWidth - OffsetWidth;

  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [TagWidth-1:0] tag_t;

  tag_t             tag_mem  [LineCount];
  roc_pkg::data_t   data_mem [LineCount];
  logic [LineCount-1:0] valid_q;

  idx_t             in_idx;
  tag_t             in_tag;
  idx_t             fill_idx;
  tag_t             fill_tag;
  logic             fwd;
  logic             line_valid;
  tag_t             line_tag;
  roc_pkg::data_t   line_data;
  logic             accept;
  roc_pkg::lookup_t lookup_d;
  roc_pkg::lookup_t out_q;
  logic             out_valid_q;

  assign in_idx   = in_req_i.addr[OffsetWidth +: IdxWidth];
  assign in_tag   = in_req_i.addr[roc_pkg::AddrWidth-1 -: TagWidth];
  assign fill_idx = fill_i.addr[OffsetWidth +: IdxWidth];
  assign fill_tag = fill_i.addr[roc_pkg::AddrWidth-1 -: TagWidth];

  // --------------------
  // Lookup
  // --------------------

  // A fill landing this cycle is seen by the lookup taken in the same cycle
  assign fwd        = fill_valid_i && (fill_idx == in_idx);
  assign line_valid = fwd ? 1'b1 : valid_q[in_idx];
  assign line_tag   = fwd ? fill_tag : tag_mem[in_idx];
  assign line_data  = fwd ? fill_i.data : data_mem[in_idx];

  always_comb begin
    lookup_d.addr      = in_req_i.addr;
    lookup_d.cacheable = in_cacheable_i;
    lookup_d.hit       = in_cacheable_i && line_valid && (line_tag == in_tag);
    lookup_d.data      = line_data;
  end

  assign in_ready_o = (!out_valid_q || out_ready_i) && !flush_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_q <= lookup_d;
    end
  end

  assign out_o       = out_q;
  assign out_valid_o = out_valid_q;

  // --------------------
  // Arrays
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_mem[fill_idx]  <= fill_tag;
      data_mem[fill_idx] <= fill_i.data;
    end
  end

  // Flush waits for an idle refill, so no fill can be in flight
  a_no_fill_on_flush : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(fill_valid_i && flush_i)
  );

endmodule

`default_nettype wire

// ==== src/roc_pkg.sv ====
// Read-only cache shared widths and payload structs
`default_nettype none

package roc_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // --------------------
  // Payload structs
  // --------------------

  // Cacheable window, start inclusive and end exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } region_t;

  // Upstream read request
  typedef struct packed {
    addr_t addr;
  } req_t;

  // Result of the line store lookup
  typedef struct packed {
    addr_t addr;
    logic  cacheable;
    logic  hit;
    data_t data;
  } lookup_t;

  // Memory read response
  typedef struct packed {
    data_t data;
    logic  error;
  } mem_rsp_t;

  // Response returned upstream
  typedef struct packed {
    data_t data;
    logic  error;
  } rsp_t;

  // Line write from the refill stage
  typedef struct packed {
    addr_t addr;
    data_t data;
  } fill_t;

endpackage

`default_nettype wire

// ==== src/roc_refill.sv ====
// Miss and bypass handler that fetches from memory, fills lines and responds
`timescale 1ns/1ps
`default_nettype none

module roc_refill (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // Lookup result
  input  wire roc_pkg::lookup_t   in_i,
  input  wire logic               in_valid_i,
  output logic                    in_ready_o,
  // Upstream response
  output roc_pkg::rsp_t           rsp_o,
  output logic                    rsp_valid_o,
  input  wire logic               rsp_ready_i,
  // Memory port
  output roc_pkg::addr_t          mem_addr_o,
  output logic                    mem_req_valid_o,
  input  wire logic               mem_req_ready_i,
  input  wire roc_pkg::mem_rsp_t  mem_rsp_i,
  input  wire logic               mem_rsp_valid_i,
  // Line write
  output roc_pkg::fill_t          fill_o,
  output logic                    fill_valid_o,
  // No miss in progress
  output logic                    idle_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRequest,
    StWait,
    StRespond
  } state_e;

  state_e        state_q;
  state_e        state_d;
  roc_pkg::rsp_t rsp_q;
  logic          fill_d;
  logic          fill_q;
  logic          idle_q;

  // --------------------
  // FSM
  // --------------------

  // The lookup stays at the input until its response is taken
  always_comb begin
    state_d         = state_q;
    fill_d          = 1'b0;
    in_ready_o      = 1'b0;
    rsp_valid_o     = 1'b0;
    mem_req_valid_o = 1'b0;
    rsp_o           = rsp_q;
    case (state_q)
      StIdle: begin
        // Hits go straight through
        rsp_o.data  = in_i.data;
        rsp_o.error = 1'b0;
        if (in_valid_i) begin
          if (in_i.hit) begin
            rsp_valid_o = 1'b1;
            in_ready_o  = rsp_ready_i;
          end else begin
            state_d = StRequest;
          end
        end
      end
      StRequest: begin
        mem_req_valid_o = 1'b1;
        if (mem_req_ready_i) begin
          state_d = StWait;
        end
      end
      StWait: begin
        if (mem_rsp_valid_i) begin
          state_d = StRespond;
          // Faulty data is never cached
          fill_d  = in_i.cacheable && !mem_rsp_i.error;
        end
      end
      StRespond: begin
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          in_ready_o = 1'b1;
          state_d    = StIdle;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      fill_q  <= 1'b0;
      idle_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      fill_q  <= fill_d;
      idle_q  <= (state_d == StIdle);
    end
  end

  // Memory data held for the response and the fill
  always_ff @(posedge clk_i) begin
    if ((state_q == StWait) && mem_rsp_valid_i) begin
      rsp_q.data  <= mem_rsp_i.data;
      rsp_q.error <= mem_rsp_i.error;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign mem_addr_o   = in_i.addr;
  assign fill_o.addr  = in_i.addr;
  assign fill_o.data  = rsp_q.data;
  assign fill_valid_o = fill_q;
  assign idle_o       = idle_q;

  // One request outstanding, so a response only comes while waiting
  a_rsp_in_wait : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> (state_q == StWait)
  );

endmodule

`default_nettype wire

// ==== src/roc_region_decode.sv ====
// Request stage that registers a read and marks it cacheable or bypass
`timescale 1ns/1ps
`default_nettype none

module roc_region_decode #(
  parameter int unsigned NrRegions = 2
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              enable_i,
  input  wire roc_pkg::region_t [NrRegions-1:0]  regions_i,
  // Upstream request
  input  wire roc_pkg::req_t                     req_i,
  input  wire logic                              req_valid_i,
  output logic                                   req_ready_o,
  // Towards the line store
  output roc_pkg::req_t                          out_req_o,
  output logic                                   out_cacheable_o,
  output logic                                   out_valid_o,
  input  wire logic                              out_ready_i,
  // Flush in progress
  input  wire logic                              flush_i
);

  logic          in_region;
  logic          cacheable;
  logic          accept;
  logic          valid_q;
  logic          cacheable_q;
  roc_pkg::req_t req_q;

  // --------------------
  // Region match
  // --------------------
  always_comb begin
    in_region = 1'b0;
    for (int unsigned i = 0; i < NrRegions; i++) begin
      if ((req_i.addr >= regions_i[i].start_addr) &&
          (req_i.addr < regions_i[i].end_addr)) begin
        in_region = 1'b1;
      end
    end
  end

  // Disabled cache sends everything to memory
  assign cacheable = enable_i && in_region;

  // --------------------
  // One-entry stage
  // --------------------
  assign req_ready_o = (!valid_q || out_ready_i) && !flush_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q       <= req_i;
      cacheable_q <= cacheable;
    end
  end

  assign out_req_o       = req_q;
  assign out_cacheable_o = cacheable_q;
  assign out_valid_o     = valid_q;

  // Held request must not change before the line store takes it
  a_out_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_req_o))
  );

endmodule

`default_nettype wire

// ==== src/roc_top.sv ====
// Read-only cache top level joining decode, line store and refill
`timescale 1ns/1ps
`default_nettype none

module roc_top #(
  parameter int unsigned LineCount = 16,
  parameter int unsigned NrRegions = 2
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              enable_i,
  input  wire roc_pkg::region_t [NrRegions-1:0]  regions_i,
  // Request
  input  wire roc_pkg::req_t                     req_i,
  input  wire logic                              req_valid_i,
  output logic                                   req_ready_o,
  // Response
  output roc_pkg::rsp_t                          rsp_o,
  output logic                                   rsp_valid_o,
  input  wire logic                              rsp_ready_i,
  // Memory
  output roc_pkg::addr_t                         mem_addr_o,
  output logic                                   mem_req_valid_o,
  input  wire logic                              mem_req_ready_i,
  input  wire roc_pkg::mem_rsp_t                 mem_rsp_i,
  input  wire logic                              mem_rsp_valid_i,
  // Flush
  input  wire logic                              flush_valid_i,
  output logic                                   flush_ready_o
);

  roc_pkg::req_t    dec_req;
  logic             dec_cacheable;
  logic             dec_valid;
  logic             dec_ready;
  roc_pkg::lookup_t lookup;
  logic             lookup_valid;
  logic             lookup_ready;
  roc_pkg::fill_t   fill;
  logic             fill_valid;
  logic             refill_idle;
  logic             flush;

  // Flush only with an empty lookup register and no miss in progress
  assign flush_ready_o = !lookup_valid && refill_idle;
  assign flush         = flush_valid_i && flush_ready_o;

  roc_region_decode #(
    .NrRegions ( NrRegions )
  ) i_region_decode (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .enable_i        ( enable_i      ),
    .regions_i       ( regions_i     ),
    .req_i           ( req_i         ),
    .req_valid_i     ( req_valid_i   ),
    .req_ready_o     ( req_ready_o   ),
    .out_req_o       ( dec_req       ),
    .out_cacheable_o ( dec_cacheable ),
    .out_valid_o     ( dec_valid     ),
    .out_ready_i     ( dec_ready     ),
    .flush_i         ( flush         )
  );

  roc_line_store #(
    .LineCount ( LineCount )
  ) i_line_store (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .in_req_i       ( dec_req       ),
    .in_cacheable_i ( dec_cacheable ),
    .in_valid_i     ( dec_valid     ),
    .in_ready_o     ( dec_ready     ),
    .out_o          ( lookup        ),
    .out_valid_o    ( lookup_valid  ),
    .out_ready_i    ( lookup_ready  ),
    .fill_i         ( fill          ),
    .fill_valid_i   ( fill_valid    ),
    .flush_i        ( flush         )
  );

  roc_refill i_refill (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .in_i            ( lookup          ),
    .in_valid_i      ( lookup_valid    ),
    .in_ready_o      ( lookup_ready    ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .fill_o          ( fill            ),
    .fill_valid_o    ( fill_valid      ),
    .idle_o          ( refill_idle     )
  );

endmodule

`default_nettype wire

// ==== tb/roc_stimulus.txt ====
# op addr expected_data mem_access  (hex; enable uses addr as the level)
# pread streams requests under random back-pressure, mem_access unused
enable 1 0 0
read 1000 5A5A4A5A 1
read 1000 5A5A4A5A 0
read 1004 5A5A4A5E 1
read 1004 5A5A4A5E 0
read 8000 5A5ADA5A 1
read 8000 5A5ADA5A 1
enable 0 0 0
read 1008 5A5A4A52 1
read 1008 5A5A4A52 1
read 1000 5A5A4A5A 1
enable 1 0 0
read 1000 5A5A4A5A 0
read 1010 5A5A4A4A 1
read 1050 5A5A4A0A 1
read 1010 5A5A4A4A 1
read 1010 5A5A4A4A 0
flush 0 0 0
read 1000 5A5A4A5A 1
read 1000 5A5A4A5A 0
read 3000 5A5A6A5A 1
read 3000 5A5A6A5A 1
read 3100 5A5A6B5A 1
read 3100 5A5A6B5A 0
pread 1100 5A5A4B5A 0
pread 1104 5A5A4B5E 0
pread 1100 5A5A4B5A 0
pread 8000 5A5ADA5A 0
pread 1104 5A5A4B5E 0
pread 3000 5A5A6A5A 0
pread 1108 5A5A4B52 0
pread 1100 5A5A4B5A 0
read 1108 5A5A4B52 0

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source, 4 ns period with a 4-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_roc_top.sv ====
// Testbench for the read-only cache, driven from a stimulus file
`timescale 1ns/1ps
`default_nettype none

module tb_roc_top;

  localparam int unsigned   Timeout = 200;
  localparam roc_pkg::data_t DataXor = 32'h5A5A_5A5A;

  logic                         clk;
  logic                         rst_n;
  logic                         enable_i;
  roc_pkg::region_t [1:0]       regions_i;
  roc_pkg::req_t                req_i;
  logic                         req_valid_i;
  logic                         req_ready_o;
  roc_pkg::rsp_t                rsp_o;
  logic                         rsp_valid_o;
  logic                         rsp_ready_i;
  roc_pkg::addr_t               mem_addr_o;
  logic                         mem_req_valid_o;
  logic                         mem_req_ready_i;
  roc_pkg::mem_rsp_t            mem_rsp_i;
  logic                         mem_rsp_valid_i;
  logic                         flush_valid_i;
  logic                         flush_ready_o;

  int                           errors = 0;
  int                           cycle = 0;
  int                           mem_count = 0;
  int                           rsp_count = 0;
  int                           accept_edge = 0;
  int                           last_rsp_edge = 0;
  logic                         stall_mode = 1'b0;
  roc_pkg::data_t               exp_data_q[$];
  logic                         exp_err_q[$];

  tb_clock_gen #(.ResetCycles(4)) i_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  roc_top #(
    .LineCount ( 16 ),
    .NrRegions ( 2  )
  ) i_roc_top (
    .clk_i           ( clk             ),
    .rst_n_i         ( rst_n           ),
    .enable_i        ( enable_i        ),
    .regions_i       ( regions_i       ),
    .req_i           ( req_i           ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .flush_valid_i   ( flush_valid_i   ),
    .flush_ready_o   ( flush_ready_o   )
  );

  always @(posedge clk) cycle <= cycle + 1;

  // Memory flags an error in this window only
  function automatic logic in_error_window(input roc_pkg::addr_t a);
    return (a >= 32'h0000_3000) && (a < 32'h0000_3100);
  endfunction

  task automatic end_run();
    $display("Closing with %0d error(s)", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
    end_run();
  endtask

  // --------------------
  // Memory model
  // --------------------
  initial begin : memory_model
    int unsigned    delay;
    roc_pkg::addr_t a;
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    forever begin
      @(negedge clk);
      #1;
      if (rst_n && mem_req_valid_o) begin
        a     = mem_addr_o;
        delay = $urandom % 6;
        mem_count++;
        @(negedge clk);
        repeat (delay) @(negedge clk);
        mem_rsp_i.data  = a ^ DataXor;
        mem_rsp_i.error = in_error_window(a);
        mem_rsp_valid_i = 1'b1;
        @(negedge clk);
        mem_rsp_valid_i = 1'b0;
      end
    end
  end

  // Random back-pressure while streaming
  initial begin
    rsp_ready_i = 1'b1;
    forever begin
      @(negedge clk);
      rsp_ready_i = stall_mode ? (($urandom % 2) != 0) : 1'b1;
    end
  end

  // --------------------
  // Response monitor
  // --------------------
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (flush_ready_o && rsp_valid_o) begin
        errors++;
        $display("Flush was offered while a response was pending");
      end
      if (rst_n && rsp_valid_o && rsp_ready_i) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("Response arrived with no request outstanding");
        end else begin
          if (rsp_o.data !== exp_data_q[0]) begin
            errors++;
            $display("error rsp_o.data expected %h got %h", exp_data_q[0], rsp_o.data);
          end
          if (rsp_o.error !== exp_err_q[0]) begin
            errors++;
            $display("error rsp_o.error expected %h got %h", exp_err_q[0], rsp_o.error);
          end
          void'(exp_data_q.pop_front());
          void'(exp_err_q.pop_front());
        end
        last_rsp_edge = cycle + 1;
        rsp_count++;
      end
    end
  end

  // --------------------
  // Driver tasks
  // --------------------
  task automatic issue_req(input roc_pkg::addr_t a, input roc_pkg::data_t d);
    int t;
    t = 0;
    @(negedge clk);
    req_i.addr  = a;
    req_valid_i = 1'b1;
    #1;
    while (!req_ready_o) begin
      @(negedge clk);
      #1;
      t++;
      if (t > Timeout) begin
        abort_on_timeout("req_ready_o");
      end
    end
    exp_data_q.push_back(d);
    exp_err_q.push_back(in_error_window(a));
    accept_edge = cycle + 1;
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_data_q.size() != 0) begin
      @(posedge clk);
      t++;
      if (t > Timeout) begin
        abort_on_timeout("outstanding responses");
      end
    end
  endtask

  task automatic single_read(input roc_pkg::addr_t a, input roc_pkg::data_t d,
                             input logic mem_exp);
    int mc;
    int rc;
    int t;
    wait_drain();
    stall_mode = 1'b0;
    mc = mem_count;
    rc = rsp_count;
    t  = 0;
    issue_req(a, d);
    while (rsp_count != rc + 1) begin
      @(posedge clk);
      t++;
      if (t > Timeout) begin
        abort_on_timeout("rsp_valid_o");
      end
    end
    if ((mem_count - mc) != int'(mem_exp)) begin
      errors++;
      $display("error mem_req_valid_o count at %h expected %h got %h",
               a, mem_exp, mem_count - mc);
    end
    if (!mem_exp && (last_rsp_edge - accept_edge != 2)) begin
      errors++;
      $display("Hit at %h answered %0d cycles after acceptance instead of 2",
               a, last_rsp_edge - accept_edge);
    end
  endtask

  task automatic do_flush();
    int t;
    t = 0;
    wait_drain();
    @(negedge clk);
    flush_valid_i = 1'b1;
    #1;
    while (!flush_ready_o) begin
      @(negedge clk);
      #1;
      t++;
      if (t > Timeout) begin
        abort_on_timeout("flush_ready_o");
      end
    end
    if (req_ready_o !== 1'b0) begin
      errors++;
      $display("error req_ready_o during flush expected %h got %h", 1'b0, req_ready_o);
    end
    @(negedge clk);
    flush_valid_i = 1'b0;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int             fd;
    int             n;
    int             t;
    string          line;
    string          op;
    roc_pkg::addr_t a;
    roc_pkg::data_t d;
    logic [31:0]    m;
    void'($urandom(56));
    enable_i      = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    flush_valid_i = 1'b0;
    regions_i[0]  = '{start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    regions_i[1]  = '{start_addr: 32'h0000_3000, end_addr: 32'h0000_4000};
    t = 0;
    fd = $fopen("tb/roc_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file");
      end_run();
    end
    while (!rst_n) begin
      @(posedge clk);
      t++;
      if (t > Timeout) begin
        abort_on_timeout("reset release");
      end
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if ((n > 1) && (line[0] != 8'h23)) begin
        n = $sscanf(line, "%s %h %h %h", op, a, d, m);
        if (op == "read") begin
          single_read(a, d, m[0]);
        end else if (op == "pread") begin
          stall_mode = 1'b1;
          issue_req(a, d);
        end else if (op == "flush") begin
          do_flush();
        end else if (op == "enable") begin
          wait_drain();
          @(negedge clk);
          enable_i = a[0];
        end else begin
          errors++;
          $display("Unknown operation in the stimulus file: %s", op);
        end
      end
    end
    wait_drain();
    $fclose(fd);
    end_run();
  end

endmodule

`default_nettype wire
